//--- common/obj_pkg.sv
`default_nettype none

package obj_pkg;

    // sprite list geometry
    localparam int ENTRY_WORDS   = 8;
    localparam int ENTRY_COUNT   = 835;
    localparam int RAM_ADDR_BITS = 15;

    // field widths
    localparam int COORD_BITS   = 12;
    localparam int TILE_BITS    = 14;
    localparam int COLOR_BITS   = 8;

    // framebuffer word address is {buffer, y[7:0], x[8:2]}
    localparam int FB_ADDR_BITS = 16;

    // last position that still lands on screen
    localparam int X_LIMIT = 480;
    localparam int Y_LIMIT = 240;

    // step added by the inc bits
    localparam int POS_STEP = 16;

    // word 0: tile code in 13:0
    localparam int WORD_TILE = 0;
    // word 4: colour 7:0, flip x, flip y, reuse colour, sequence,
    // use latch y, inc y, use latch x, inc x
    localparam int WORD_ATTR = 4;
    // word 6: x 11:0, latch extra, latch master, ~use extra, ~use scroll
    localparam int WORD_X    = 6;
    // word 7: y 11:0, upper bits unused here
    localparam int WORD_Y    = 7;

    // tile code zero only updates the scroll and latch state
    typedef enum logic {
        OBJ_EMPTY,
        OBJ_SPRITE
    } obj_kind_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_LAST
    } fetch_state_t;

endpackage

`default_nettype wire

//--- obj_eval/obj_position_eval.sv
`timescale 1ns/10ps
`default_nettype none

module obj_position_eval (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dec_valid,
    input  logic [obj_pkg::TILE_BITS-1:0]  dec_tile,
    input  logic [obj_pkg::COORD_BITS-1:0] dec_x,
    input  logic [obj_pkg::COORD_BITS-1:0] dec_y,
    input  logic [obj_pkg::COLOR_BITS-1:0] dec_color,
    input  logic                           dec_flip_x,
    input  logic                           dec_flip_y,
    input  logic                           dec_use_scroll,
    input  logic                           dec_use_extra,
    input  logic                           dec_latch_extra,
    input  logic                           dec_latch_master,
    input  logic                           dec_use_latch_x,
    input  logic                           dec_inc_x,
    input  logic                           dec_use_latch_y,
    input  logic                           dec_inc_y,
    input  logic                           dec_reuse_color,
    input  obj_pkg::obj_kind_t             dec_kind,
    output logic                           exe_valid,
    output obj_pkg::obj_kind_t             exe_kind,
    output logic [obj_pkg::TILE_BITS-1:0]  exe_tile,
    output logic [obj_pkg::COORD_BITS-1:0] exe_x,
    output logic [obj_pkg::COORD_BITS-1:0] exe_y,
    output logic [obj_pkg::COLOR_BITS-1:0] exe_color,
    output logic                           exe_flip_x,
    output logic                           exe_flip_y
);
    import obj_pkg::*;

    logic [COORD_BITS-1:0] master_x, master_y;
    logic [COORD_BITS-1:0] extra_x, extra_y;
    logic [COORD_BITS-1:0] latch_x, latch_y;
    logic [COLOR_BITS-1:0] latch_color;
    logic [COORD_BITS-1:0] base_x, base_y;
    logic [COORD_BITS-1:0] step_x, step_y;
    logic [COORD_BITS-1:0] next_x, next_y;
    logic [COLOR_BITS-1:0] next_color;

    // all position sums wrap at 4096
    always_comb begin
        step_x = dec_inc_x ? COORD_BITS'(POS_STEP) : '0;
        step_y = dec_inc_y ? COORD_BITS'(POS_STEP) : '0;
        base_x = dec_x;
        base_y = dec_y;
        if (dec_use_scroll) begin
            base_x = base_x + master_x;
            base_y = base_y + master_y;
            if (dec_use_extra) begin
                base_x = base_x + extra_x;
                base_y = base_y + extra_y;
            end
        end
        next_x     = (dec_use_latch_x ? latch_x : base_x) + step_x;
        next_y     = (dec_use_latch_y ? latch_y : base_y) + step_y;
        next_color = dec_reuse_color ? latch_color : dec_color;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid   <= 1'b0;
            master_x    <= '0;
            master_y    <= '0;
            extra_x     <= '0;
            extra_y     <= '0;
            latch_x     <= '0;
            latch_y     <= '0;
            latch_color <= '0;
        end else begin
            exe_valid <= dec_valid;
            if (dec_valid) begin
                if (dec_latch_extra) begin
                    extra_x <= base_x;
                    extra_y <= base_y;
                end
                if (dec_latch_master) begin
                    master_x <= base_x;
                    master_y <= base_y;
                end
                latch_x     <= next_x;
                latch_y     <= next_y;
                latch_color <= next_color;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_kind   <= dec_kind;
            exe_tile   <= dec_tile;
            exe_x      <= next_x;
            exe_y      <= next_y;
            exe_color  <= next_color;
            exe_flip_x <= dec_flip_x;
            exe_flip_y <= dec_flip_y;
        end
    end

    // the draw path carries the same position and colour as the sequence state
    assert property (@(posedge clk) disable iff (reset)
        exe_valid |-> exe_x == latch_x && exe_y == latch_y && exe_color == latch_color);

endmodule

`default_nettype wire

//--- obj_list_engine.f
common/obj_pkg.sv
verilog/obj_entry_fetch.sv
verilog/obj_entry_decode.sv
obj_eval/obj_position_eval.sv
verilog/obj_draw_result.sv
verilog/obj_list_engine.sv
sim/obj_list_engine_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the sprite list engine testbench with Verilator
# the exit status is non-zero when the build fails or the testbench stops on an error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module obj_list_engine_tb \
    -f obj_list_engine.f \
    -o obj_list_engine_sim \
    && ./obj_dir/obj_list_engine_sim \
    || { echo "simulation run did not pass"; exit 1; }

//--- sim/obj_list_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none

module obj_list_engine_tb;
    import obj_pkg::*;

    localparam int MAX_ROWS     = 32;
    localparam int NUM_FRAMES   = 4;
    localparam int FRAME_CYCLES = ENTRY_COUNT * (ENTRY_WORDS + 1) + 20;

    logic                     clk;
    logic                     reset;
    logic                     frame_start;
    logic [RAM_ADDR_BITS-1:0] ram_addr;
    logic [15:0]              ram_data;
    logic                     draw_valid;
    logic [TILE_BITS-1:0]     draw_tile;
    logic [COORD_BITS-1:0]    draw_x;
    logic [COORD_BITS-1:0]    draw_y;
    logic [COLOR_BITS-1:0]    draw_color;
    logic                     draw_flip_x;
    logic                     draw_flip_y;
    logic [FB_ADDR_BITS-1:0]  draw_fb_addr;
    logic                     busy;
    logic                     list_done;
    logic [9:0]               draw_count;

    // sprite RAM model with one cycle read latency
    logic [15:0] ram [2**RAM_ADDR_BITS];

    // entry table of frame, entry index, used words and expected draw
    int                    n_rows;
    int                    row_frame [MAX_ROWS];
    int                    row_index [MAX_ROWS];
    logic [15:0]           row_w0 [MAX_ROWS];
    logic [15:0]           row_w4 [MAX_ROWS];
    logic [15:0]           row_w6 [MAX_ROWS];
    logic [15:0]           row_w7 [MAX_ROWS];
    bit                    row_draw [MAX_ROWS];
    logic [TILE_BITS-1:0]  row_tile [MAX_ROWS];
    logic [COORD_BITS-1:0] row_x [MAX_ROWS];
    logic [COORD_BITS-1:0] row_y [MAX_ROWS];
    logic [COLOR_BITS-1:0] row_color [MAX_ROWS];
    bit                    row_fx [MAX_ROWS];
    bit                    row_fy [MAX_ROWS];

    int   pending [$];
    logic exp_buf;
    int   seed;

    obj_list_engine uut (
        .clk, .reset, .frame_start, .ram_addr, .ram_data,
        .draw_valid, .draw_tile, .draw_x, .draw_y, .draw_color,
        .draw_flip_x, .draw_flip_y, .draw_fb_addr,
        .busy, .list_done, .draw_count
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        ram_data <= ram[ram_addr];
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_coord(input string name, input logic [COORD_BITS-1:0] got,
                               input logic [COORD_BITS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_tile(input string name, input logic [TILE_BITS-1:0] got,
                              input logic [TILE_BITS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_color(input string name, input logic [COLOR_BITS-1:0] got,
                               input logic [COLOR_BITS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_fb_addr(input string name, input logic [FB_ADDR_BITS-1:0] got,
                                 input logic [FB_ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [RAM_ADDR_BITS-1:0] got,
                              input logic [RAM_ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [9:0] got,
                               input logic [9:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic add_row(input int frame, input int idx, input logic [15:0] w0,
                           input logic [15:0] w4, input logic [15:0] w6,
                           input logic [15:0] w7, input bit drawn,
                           input logic [TILE_BITS-1:0] tile,
                           input logic [COORD_BITS-1:0] x, input logic [COORD_BITS-1:0] y,
                           input logic [COLOR_BITS-1:0] color, input bit fx, input bit fy);
        row_frame[n_rows] = frame;
        row_index[n_rows] = idx;
        row_w0[n_rows]    = w0;
        row_w4[n_rows]    = w4;
        row_w6[n_rows]    = w6;
        row_w7[n_rows]    = w7;
        row_draw[n_rows]  = drawn;
        row_tile[n_rows]  = tile;
        row_x[n_rows]     = x;
        row_y[n_rows]     = y;
        row_color[n_rows] = color;
        row_fx[n_rows]    = fx;
        row_fy[n_rows]    = fy;
        n_rows++;
    endtask

    // words 1, 2, 3 and 5 carry random filler that the engine ignores
    task automatic load_frame(input int frame);
        int base;
        for (int a = 0; a < 2**RAM_ADDR_BITS; a++) begin
            ram[a] = 16'h0000;
        end
        for (int r = 0; r < n_rows; r++) begin
            if (row_frame[r] == frame) begin
                base = row_index[r] * ENTRY_WORDS;
                ram[base + WORD_TILE] = row_w0[r];
                ram[base + 1]         = 16'($random(seed));
                ram[base + 2]         = 16'($random(seed));
                ram[base + 3]         = 16'($random(seed));
                ram[base + WORD_ATTR] = row_w4[r];
                ram[base + 5]         = 16'($random(seed));
                ram[base + WORD_X]    = row_w6[r];
                ram[base + WORD_Y]    = row_w7[r];
            end
        end
    endtask

    task automatic run_frame(input int frame);
        int                      waited;
        int                      expected;
        int                      r;
        bit                      done;
        logic [FB_ADDR_BITS-1:0] exp_fb;
        load_frame(frame);
        pending.delete();
        for (int i = 0; i < n_rows; i++) begin
            if (row_frame[i] == frame && row_draw[i]) begin
                pending.push_back(i);
            end
        end
        expected = pending.size();
        exp_buf  = ~exp_buf;

        @(posedge clk);
        #10 frame_start = 1'b1;
        @(posedge clk);
        #10 frame_start = 1'b0;

        waited = 0;
        @(negedge clk);
        while (!busy) begin
            if (waited == 4) begin
                stop_on_error("busy did not rise after frame_start");
            end else begin
                waited++;
                @(negedge clk);
            end
        end

        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (draw_valid) begin
                if (pending.size() == 0) begin
                    stop_on_error($sformatf("unexpected draw request at %0t in frame %0d",
                                            $time, frame));
                end else begin
                    r      = pending.pop_front();
                    // buffer bit weighs 2**15, each line 128 words, four pixels per word
                    exp_fb = FB_ADDR_BITS'(32768 * int'(exp_buf)
                                           + 128 * (int'(row_y[r]) % 256)
                                           + (int'(row_x[r]) / 4) % 128);
                    check_tile("draw_tile", draw_tile, row_tile[r]);
                    check_coord("draw_x", draw_x, row_x[r]);
                    check_coord("draw_y", draw_y, row_y[r]);
                    check_color("draw_color", draw_color, row_color[r]);
                    check_bit("draw_flip_x", draw_flip_x, row_fx[r]);
                    check_bit("draw_flip_y", draw_flip_y, row_fy[r]);
                    check_fb_addr("draw_fb_addr", draw_fb_addr, exp_fb);
                end
            end
            if (list_done) begin
                if (pending.size() != 0) begin
                    stop_on_error($sformatf("frame %0d ended with %0d draw requests missing",
                                            frame, pending.size()));
                end else begin
                    check_count("draw_count", draw_count, 10'(expected));
                    done = 1'b1;
                end
            end else if (waited == FRAME_CYCLES) begin
                stop_on_error($sformatf("list_done never came in frame %0d", frame));
            end else begin
                waited++;
            end
        end

        waited = 0;
        while (busy) begin
            if (waited == 4) begin
                stop_on_error("busy stayed high after list_done");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        seed        = 66630;
        reset       = 1'b1;
        frame_start = 1'b0;
        ram_data    <= 16'h0000;
        exp_buf     = 1'b0;
        n_rows      = 0;

        // frame 0 holds one absolute sprite with flip x
        add_row(0, 0, 16'h0123, 16'h0145, 16'hC064, 16'h0032, 1, 14'h0123, 12'd100, 12'd50,
                8'h45, 1, 0);
        // frame 1 has an absolute sprite, then master and extra scroll
        add_row(1, 0, 16'h0123, 16'h0245, 16'hC064, 16'h0032, 1, 14'h0123, 12'd100, 12'd50,
                8'h45, 0, 1);
        add_row(1, 1, 16'h0000, 16'h0000, 16'hE020, 16'h0010, 0, 14'h0, 12'd0, 12'd0,
                8'h00, 0, 0);
        add_row(1, 2, 16'h0200, 16'h0011, 16'h400A, 16'h0014, 1, 14'h0200, 12'd42, 12'd36,
                8'h11, 0, 0);
        add_row(1, 3, 16'h0000, 16'h0000, 16'hD005, 16'h0007, 0, 14'h0, 12'd0, 12'd0,
                8'h00, 0, 0);
        add_row(1, 4, 16'h0201, 16'h0012, 16'h000A, 16'h0014, 1, 14'h0201, 12'd47, 12'd43,
                8'h12, 0, 0);
        add_row(1, 5, 16'h0202, 16'h0013, 16'h400A, 16'h0014, 1, 14'h0202, 12'd42, 12'd36,
                8'h13, 0, 0);
        // sums wrap at 4096
        add_row(1, 6, 16'h0203, 16'h0014, 16'h4FFA, 16'h0FFF, 1, 14'h0203, 12'd26, 12'd15,
                8'h14, 0, 0);
        // frame 2 clears both scrolls, then tests latch rules and culling
        add_row(2, 0, 16'h0000, 16'h0000, 16'hF000, 16'h0000, 0, 14'h0, 12'd0, 12'd0,
                8'h00, 0, 0);
        add_row(2, 1, 16'h0300, 16'h0030, 16'hC0C8, 16'h0064, 1, 14'h0300, 12'd200, 12'd100,
                8'h30, 0, 0);
        add_row(2, 2, 16'h0301, 16'hF477, 16'hC005, 16'h0009, 1, 14'h0301, 12'd216, 12'd116,
                8'h30, 0, 0);
        add_row(2, 3, 16'h0302, 16'h6055, 16'hC007, 16'h0028, 1, 14'h0302, 12'd216, 12'd56,
                8'h55, 0, 0);
        add_row(2, 4, 16'h0303, 16'h0001, 16'hC1E1, 16'h000A, 0, 14'h0, 12'd0, 12'd0,
                8'h00, 0, 0);
        add_row(2, 5, 16'h0304, 16'h0001, 16'hC00A, 16'h00F1, 0, 14'h0, 12'd0, 12'd0,
                8'h00, 0, 0);
        add_row(2, 6, 16'h0305, 16'h0302, 16'hC1E0, 16'h00F0, 1, 14'h0305, 12'd480, 12'd240,
                8'h02, 1, 1);
        add_row(2, 7, 16'h0000, 16'h0003, 16'hC064, 16'h0032, 0, 14'h0, 12'd0, 12'd0,
                8'h00, 0, 0);
        // frame 3 has no rows so the RAM stays all zero

        repeat (2) @(posedge clk);
        #10 reset = 1'b0;
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("draw_valid", draw_valid, 1'b0);
        check_bit("list_done", list_done, 1'b0);
        check_count("draw_count", draw_count, 10'd0);
        check_addr("ram_addr", ram_addr, '0);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/obj_draw_result.sv
`timescale 1ns/10ps
`default_nettype none

module obj_draw_result (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             list_start,
    input  logic                             list_end,
    input  logic                             exe_valid,
    input  obj_pkg::obj_kind_t               exe_kind,
    input  logic [obj_pkg::TILE_BITS-1:0]    exe_tile,
    input  logic [obj_pkg::COORD_BITS-1:0]   exe_x,
    input  logic [obj_pkg::COORD_BITS-1:0]   exe_y,
    input  logic [obj_pkg::COLOR_BITS-1:0]   exe_color,
    input  logic                             exe_flip_x,
    input  logic                             exe_flip_y,
    output logic                             draw_valid,
    output logic [obj_pkg::TILE_BITS-1:0]    draw_tile,
    output logic [obj_pkg::COORD_BITS-1:0]   draw_x,
    output logic [obj_pkg::COORD_BITS-1:0]   draw_y,
    output logic [obj_pkg::COLOR_BITS-1:0]   draw_color,
    output logic                             draw_flip_x,
    output logic                             draw_flip_y,
    output logic [obj_pkg::FB_ADDR_BITS-1:0] draw_fb_addr,
    output logic                             list_done,
    output logic [9:0]                       draw_count
);
    import obj_pkg::*;

    logic       draw_buf;
    logic       start_d;
    logic       end_d;
    logic       hit;
    logic [9:0] count;
    logic [9:0] count_next;

    // visible sprite, inside the screen window
    assign hit = exe_valid && exe_kind == OBJ_SPRITE && exe_x <= X_LIMIT && exe_y <= Y_LIMIT;
    assign count_next = count + 10'(hit);

    // list markers act two cycles late so entries still in flight stay with their list
    always_ff @(posedge clk) begin
        if (reset) begin
            draw_valid <= 1'b0;
            list_done  <= 1'b0;
            start_d    <= 1'b0;
            end_d      <= 1'b0;
            draw_buf   <= 1'b0;
            count      <= '0;
            draw_count <= '0;
        end else begin
            draw_valid <= hit;
            list_done  <= end_d;
            start_d    <= list_start;
            end_d      <= list_end;
            if (end_d) begin
                draw_count <= count_next;
            end
            if (start_d) begin
                draw_buf <= ~draw_buf;
                count    <= '0;
            end else begin
                count <= count_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            draw_tile    <= exe_tile;
            draw_x       <= exe_x;
            draw_y       <= exe_y;
            draw_color   <= exe_color;
            draw_flip_x  <= exe_flip_x;
            draw_flip_y  <= exe_flip_y;
            draw_fb_addr <= {draw_buf, exe_y[7:0], exe_x[8:2]};
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_entry_decode.sv
`timescale 1ns/10ps
`default_nettype none

module obj_entry_decode (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           entry_valid,
    input  logic [15:0]                    entry_w0,
    input  logic [15:0]                    entry_w1,
    input  logic [15:0]                    entry_w2,
    input  logic [15:0]                    entry_w3,
    input  logic [15:0]                    entry_w4,
    input  logic [15:0]                    entry_w5,
    input  logic [15:0]                    entry_w6,
    input  logic [15:0]                    entry_w7,
    output logic                           dec_valid,
    output logic [obj_pkg::TILE_BITS-1:0]  dec_tile,
    output logic [obj_pkg::COORD_BITS-1:0] dec_x,
    output logic [obj_pkg::COORD_BITS-1:0] dec_y,
    output logic [obj_pkg::COLOR_BITS-1:0] dec_color,
    output logic                           dec_flip_x,
    output logic                           dec_flip_y,
    output logic                           dec_use_scroll,
    output logic                           dec_use_extra,
    output logic                           dec_latch_extra,
    output logic                           dec_latch_master,
    output logic                           dec_use_latch_x,
    output logic                           dec_inc_x,
    output logic                           dec_use_latch_y,
    output logic                           dec_inc_y,
    output logic                           dec_reuse_color,
    output obj_pkg::obj_kind_t             dec_kind
);
    import obj_pkg::*;

    logic [15:0] w [ENTRY_WORDS];

    assign w = '{entry_w0, entry_w1, entry_w2, entry_w3,
                 entry_w4, entry_w5, entry_w6, entry_w7};

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= entry_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (entry_valid) begin
            dec_tile <= w[WORD_TILE][TILE_BITS-1:0];
            dec_kind <= (w[WORD_TILE][TILE_BITS-1:0] == '0) ? OBJ_EMPTY : OBJ_SPRITE;

            dec_color       <= w[WORD_ATTR][COLOR_BITS-1:0];
            dec_flip_x      <= w[WORD_ATTR][8];
            dec_flip_y      <= w[WORD_ATTR][9];
            dec_reuse_color <= w[WORD_ATTR][10];
            // bit 11 is the sequence flag, not used
            dec_use_latch_y <= w[WORD_ATTR][12];
            dec_inc_y       <= w[WORD_ATTR][13];
            dec_use_latch_x <= w[WORD_ATTR][14];
            dec_inc_x       <= w[WORD_ATTR][15];

            dec_x            <= w[WORD_X][COORD_BITS-1:0];
            dec_latch_extra  <= w[WORD_X][12];
            dec_latch_master <= w[WORD_X][13];
            // both scroll enables are active low in RAM
            dec_use_extra    <= ~w[WORD_X][14];
            dec_use_scroll   <= ~w[WORD_X][15];

            dec_y <= w[WORD_Y][COORD_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

//--- verilog/obj_entry_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module obj_entry_fetch (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              frame_start,
    input  logic [15:0]                       ram_data,
    output logic [obj_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output logic                              entry_valid,
    output logic [15:0]                       entry_w0,
    output logic [15:0]                       entry_w1,
    output logic [15:0]                       entry_w2,
    output logic [15:0]                       entry_w3,
    output logic [15:0]                       entry_w4,
    output logic [15:0]                       entry_w5,
    output logic [15:0]                       entry_w6,
    output logic [15:0]                       entry_w7,
    output logic                              list_start,
    output logic                              list_end,
    output logic                              busy
);
    import obj_pkg::*;

    fetch_state_t state;
    logic [$clog2(ENTRY_COUNT)-1:0] entry_idx;
    logic [3:0] phase;
    logic [15:0] words [ENTRY_WORDS];

    // phases 0..7 address the words, phase 8 only waits for word 7
    assign ram_addr = RAM_ADDR_BITS'({entry_idx, phase[2:0]});

    assign entry_w0 = words[WORD_TILE];
    assign entry_w1 = words[1];
    assign entry_w2 = words[2];
    assign entry_w3 = words[3];
    assign entry_w4 = words[WORD_ATTR];
    assign entry_w5 = words[5];
    assign entry_w6 = words[WORD_X];
    assign entry_w7 = words[WORD_Y];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= FETCH_IDLE;
            entry_idx   <= '0;
            phase       <= '0;
            entry_valid <= 1'b0;
            list_start  <= 1'b0;
            list_end    <= 1'b0;
            busy        <= 1'b0;
        end else begin
            entry_valid <= 1'b0;
            list_start  <= 1'b0;
            list_end    <= 1'b0;
            if (frame_start) begin
                state      <= FETCH_READ;
                entry_idx  <= '0;
                phase      <= '0;
                busy       <= 1'b1;
                list_start <= 1'b1;
                // close off a list that was still running
                list_end   <= busy;
            end else begin
                case (state)
                    FETCH_READ: begin
                        if (phase == 4'd8) begin
                            entry_valid <= 1'b1;
                            phase       <= '0;
                            if (entry_idx == ENTRY_COUNT - 1) begin
                                state     <= FETCH_LAST;
                                entry_idx <= '0;
                            end else begin
                                entry_idx <= entry_idx + 1'b1;
                            end
                        end else begin
                            phase <= phase + 4'd1;
                        end
                    end
                    FETCH_LAST: begin
                        // let the last entry drain through decode and execute
                        if (phase == 4'd3) begin
                            state    <= FETCH_IDLE;
                            phase    <= '0;
                            busy     <= 1'b0;
                            list_end <= 1'b1;
                        end else begin
                            phase <= phase + 4'd1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // word n comes back one cycle after its address
    always_ff @(posedge clk) begin
        if (state == FETCH_READ && phase != 4'd0) begin
            words[3'(phase - 4'd1)] <= ram_data;
        end
    end

    // one entry per nine cycles keeps the later stages free of stalls
    assert property (@(posedge clk) disable iff (reset) entry_valid |=> !entry_valid);

endmodule

`default_nettype wire

//--- verilog/obj_list_engine.sv
`timescale 1ns/10ps
`default_nettype none

module obj_list_engine (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             frame_start,
    output logic [obj_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    input  logic [15:0]                      ram_data,
    output logic                             draw_valid,
    output logic [obj_pkg::TILE_BITS-1:0]    draw_tile,
    output logic [obj_pkg::COORD_BITS-1:0]   draw_x,
    output logic [obj_pkg::COORD_BITS-1:0]   draw_y,
    output logic [obj_pkg::COLOR_BITS-1:0]   draw_color,
    output logic                             draw_flip_x,
    output logic                             draw_flip_y,
    output logic [obj_pkg::FB_ADDR_BITS-1:0] draw_fb_addr,
    output logic                             busy,
    output logic                             list_done,
    output logic [9:0]                       draw_count
);
    import obj_pkg::*;

    logic entry_valid, list_start, list_end;
    logic [15:0] entry_w0, entry_w1, entry_w2, entry_w3;
    logic [15:0] entry_w4, entry_w5, entry_w6, entry_w7;

    logic                  dec_valid;
    logic [TILE_BITS-1:0]  dec_tile;
    logic [COORD_BITS-1:0] dec_x, dec_y;
    logic [COLOR_BITS-1:0] dec_color;
    logic                  dec_flip_x, dec_flip_y;
    logic                  dec_use_scroll, dec_use_extra;
    logic                  dec_latch_extra, dec_latch_master;
    logic                  dec_use_latch_x, dec_inc_x;
    logic                  dec_use_latch_y, dec_inc_y;
    logic                  dec_reuse_color;
    obj_kind_t             dec_kind;

    logic                  exe_valid;
    obj_kind_t             exe_kind;
    logic [TILE_BITS-1:0]  exe_tile;
    logic [COORD_BITS-1:0] exe_x, exe_y;
    logic [COLOR_BITS-1:0] exe_color;
    logic                  exe_flip_x, exe_flip_y;

    obj_entry_fetch u_fetch (
        .clk, .reset, .frame_start, .ram_data, .ram_addr, .entry_valid,
        .entry_w0, .entry_w1, .entry_w2, .entry_w3,
        .entry_w4, .entry_w5, .entry_w6, .entry_w7,
        .list_start, .list_end, .busy
    );

    obj_entry_decode u_decode (
        .clk, .reset, .entry_valid,
        .entry_w0, .entry_w1, .entry_w2, .entry_w3,
        .entry_w4, .entry_w5, .entry_w6, .entry_w7,
        .dec_valid, .dec_tile, .dec_x, .dec_y, .dec_color, .dec_flip_x, .dec_flip_y,
        .dec_use_scroll, .dec_use_extra, .dec_latch_extra, .dec_latch_master,
        .dec_use_latch_x, .dec_inc_x, .dec_use_latch_y, .dec_inc_y,
        .dec_reuse_color, .dec_kind
    );

    obj_position_eval u_eval (
        .clk, .reset,
        .dec_valid, .dec_tile, .dec_x, .dec_y, .dec_color, .dec_flip_x, .dec_flip_y,
        .dec_use_scroll, .dec_use_extra, .dec_latch_extra, .dec_latch_master,
        .dec_use_latch_x, .dec_inc_x, .dec_use_latch_y, .dec_inc_y,
        .dec_reuse_color, .dec_kind,
        .exe_valid, .exe_kind, .exe_tile, .exe_x, .exe_y, .exe_color,
        .exe_flip_x, .exe_flip_y
    );

    obj_draw_result u_result (
        .clk, .reset, .list_start, .list_end,
        .exe_valid, .exe_kind, .exe_tile, .exe_x, .exe_y, .exe_color,
        .exe_flip_x, .exe_flip_y,
        .draw_valid, .draw_tile, .draw_x, .draw_y, .draw_color,
        .draw_flip_x, .draw_flip_y, .draw_fb_addr, .list_done, .draw_count
    );

endmodule

`default_nettype wire
